// ==== source/io_pkg.sv ====
// shared widths, region codes, latch bit positions and read selects of the centipede io block
package io_pkg;

   // cpu bus
   localparam int ADDR_W = 14;
   localparam int DATA_W = 8;

   // input bundles
   localparam int PLAYER_W = 10;
   localparam int TB_W = 8;
   localparam int TB_CNT_W = 4;

   // output latch fields
   localparam int LED_W = 4;
   localparam int COIN_W = 3;
   localparam int FLIP_BIT = 7;
   localparam int LED_LSB = 3;

   // regions, compared against address bits 13..10
   localparam logic [3:0] REGION_SWITCH = 4'd2;
   localparam logic [3:0] REGION_INPUT = 4'd3;
   localparam logic [3:0] REGION_OUT0 = 4'd7;
   localparam logic [3:0] REGION_STEER = 4'd9;

   // which input word a read returns
   typedef enum logic [1:0]
   {
      SEL_NONE,
      SEL_SWITCH,
      SEL_IN0,
      SEL_IN1
   } io_sel_t;

endpackage

// ==== source/io_addr_decode.sv ====
// address decoder, turns bus address and strobe into a read select and write pulses
`timescale 1ns/1ps

module io_addr_decode (
   input  logic [io_pkg::ADDR_W-1:0] addr_i,
   input  logic                      rw_n_i,
   input  logic                      wr_i,
   output io_pkg::io_sel_t           sel_o,
   output logic                      out_wr_o,
   output logic                      steer_clr_o
);

   logic [3:0] region;
   logic       write;

   // top four address bits pick the 1k region
   assign region = addr_i[io_pkg::ADDR_W-1 -: 4];

   // the strobe only counts as a write while the bus says write
   assign write = wr_i & ~rw_n_i;

   always_comb
   begin
      sel_o = io_pkg::SEL_NONE;
      if (rw_n_i)
      begin
         if (region == io_pkg::REGION_INPUT)
         begin
            // bit 1 splits in0 from in1
            sel_o = addr_i[1] ? io_pkg::SEL_IN1 : io_pkg::SEL_IN0;
         end
         else if (region == io_pkg::REGION_SWITCH)
         begin
            sel_o = io_pkg::SEL_SWITCH;
         end
      end
   end

   assign out_wr_o = write && (region == io_pkg::REGION_OUT0);
   assign steer_clr_o = write && (region == io_pkg::REGION_STEER);

   // latch and steering clear live in different regions
   always_comb
   begin
      assert (!(out_wr_o && steer_clr_o))
         else $error("out0 write and steering clear decoded together");
   end

endmodule

// ==== source/trakball_axis.sv ====
// one trackball axis with pin synchroniser, edge detect and up/down count
`timescale 1ns/1ps

module trakball_axis (
   input  logic                        s_6mhz,
   input  logic                        reset,
   input  logic                        ck_i,
   input  logic                        dir_i,
   input  logic                        clr_i,
   output logic [io_pkg::TB_CNT_W-1:0] count_o,
   output logic                        dir_o
);

   logic [1:0]                  ck_sync;
   logic [1:0]                  dir_sync;
   logic                        ck_prev;
   logic                        ck_rise;
   logic                        dir_q;
   logic [io_pkg::TB_CNT_W-1:0] count_q;

   // rising edge seen at the output of the second stage
   assign ck_rise = ck_sync[1] & ~ck_prev;

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         ck_sync <= '0;
         dir_sync <= '0;
         ck_prev <= 1'b0;
         dir_q <= 1'b0;
         count_q <= '0;
      end
      else
      begin
         ck_sync <= {ck_sync[0], ck_i};
         dir_sync <= {dir_sync[0], dir_i};
         ck_prev <= ck_sync[1];
         // direction is captured with the same sample as the clock edge
         if (ck_rise)
            dir_q <= dir_sync[1];
         // clear beats a clock edge in the same cycle
         if (clr_i)
            count_q <= '0;
         else if (ck_rise)
         begin
            if (dir_sync[1])
               count_q <= count_q + io_pkg::TB_CNT_W'(1);
            else
               count_q <= count_q - io_pkg::TB_CNT_W'(1);
         end
      end
   end

   assign count_o = count_q;
   assign dir_o = dir_q;

   // a steering clear always leaves the count at zero
   clr_zeroes_count: assert property (@(posedge s_6mhz) disable iff (reset)
      clr_i |=> (count_q == '0));

endmodule

// ==== source/coin_led_latch.sv ====
// bit addressable output latch driving flip, leds and coin counters
`timescale 1ns/1ps

module coin_led_latch (
   input  logic                      s_6mhz,
   input  logic                      reset,
   input  logic                      wr_i,
   input  logic [2:0]                bit_sel_i,
   input  logic                      bit_i,
   output logic                      flip_o,
   output logic [io_pkg::LED_W-1:0]  led_o,
   output logic [io_pkg::COIN_W-1:0] coin_ctr_o
);

   logic [io_pkg::DATA_W-1:0] latch_q;
   logic [io_pkg::DATA_W-1:0] keep_mask;

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         latch_q <= '0;
      else if (wr_i)
         latch_q[bit_sel_i] <= bit_i;
   end

   // field split, flip on top, leds in the middle, coins at the bottom
   assign flip_o = latch_q[io_pkg::FLIP_BIT];
   assign led_o = latch_q[io_pkg::LED_LSB +: io_pkg::LED_W];
   assign coin_ctr_o = latch_q[io_pkg::COIN_W-1:0];

   // bits that the current write leaves alone
   assign keep_mask = wr_i ? ~(io_pkg::DATA_W'(1) << bit_sel_i) : '1;

   unaddressed_bits_hold: assert property (@(posedge s_6mhz) disable iff (reset)
      1'b1 |=> (((latch_q ^ $past(latch_q)) & $past(keep_mask)) == '0));

endmodule

// ==== source/io_read_mux.sv ====
// read data assembly, builds the input words and picks one for the bus
`timescale 1ns/1ps

module io_read_mux (
   input  io_pkg::io_sel_t             sel_i,
   input  logic                        a0_i,
   input  logic [io_pkg::PLAYER_W-1:0] player_i,
   input  logic [7:0]                  joystick_i,
   input  logic [7:0]                  sw1_i,
   input  logic [7:0]                  sw2_i,
   input  logic [io_pkg::TB_CNT_W-1:0] h_count_i,
   input  logic [io_pkg::TB_CNT_W-1:0] v_count_i,
   input  logic                        h_dir_i,
   input  logic                        v_dir_i,
   output logic [io_pkg::DATA_W-1:0]   rdata_o
);

   logic [io_pkg::DATA_W-1:0] in0_hi;
   logic [io_pkg::DATA_W-1:0] in0_lo;
   logic [io_pkg::DATA_W-1:0] in1_lo;

   // coin_r, coin_c, coin_l, slam, fire2, fire1, start2, start1
   assign in0_hi = {player_i[9], player_i[8], player_i[7], player_i[4],
                    player_i[1], player_i[0], player_i[3], player_i[2]};

   // vblank is gone and reads as 0
   assign in0_lo = {h_dir_i, 1'b0, player_i[6], player_i[5], h_count_i};

   assign in1_lo = {v_dir_i, 3'b000, v_count_i};

   always_comb
   begin
      case (sel_i)
         io_pkg::SEL_IN0:
         begin
            rdata_o = a0_i ? in0_hi : in0_lo;
         end
         io_pkg::SEL_IN1:
         begin
            rdata_o = a0_i ? joystick_i : in1_lo;
         end
         io_pkg::SEL_SWITCH:
         begin
            rdata_o = a0_i ? sw2_i : sw1_i;
         end
         default:
         begin
            // rom, ram, pokey, playfield and colour ram are not here
            rdata_o = '0;
         end
      endcase
   end

endmodule

// ==== source/centipede_io.sv ====
// centipede memory mapped io, decode, trackball counters, output latch and read data
`timescale 1ns/1ps

module centipede_io (
   input  logic                        s_6mhz,
   input  logic                        reset,
   input  logic [io_pkg::ADDR_W-1:0]   bus_addr_i,
   input  logic [io_pkg::DATA_W-1:0]   bus_wdata_i,
   input  logic                        bus_rw_n_i,
   input  logic                        bus_wr_i,
   output logic [io_pkg::DATA_W-1:0]   bus_rdata_o,
   input  logic [io_pkg::PLAYER_W-1:0] player_i,
   input  logic [7:0]                  joystick_i,
   input  logic [7:0]                  sw1_i,
   input  logic [7:0]                  sw2_i,
   input  logic [io_pkg::TB_W-1:0]     trakball_i,
   output logic                        flip_o,
   output logic [io_pkg::LED_W-1:0]    led_o,
   output logic [io_pkg::COIN_W-1:0]   coin_ctr_o
);

   io_pkg::io_sel_t             sel;
   logic                        out_wr;
   logic                        steer_clr;
   logic                        flip;
   logic                        h_dir_pin;
   logic                        h_ck_pin;
   logic                        v_dir_pin;
   logic                        v_ck_pin;
   logic [io_pkg::TB_CNT_W-1:0] h_count;
   logic [io_pkg::TB_CNT_W-1:0] v_count;
   logic                        h_dir;
   logic                        v_dir;

   io_addr_decode decode_inst (
      .addr_i      (bus_addr_i),
      .rw_n_i      (bus_rw_n_i),
      .wr_i        (bus_wr_i),
      .sel_o       (sel),
      .out_wr_o    (out_wr),
      .steer_clr_o (steer_clr)
   );

   // address bits 2..0 pick the latch bit, data bit 7 is the value
   coin_led_latch latch_inst (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .wr_i       (out_wr),
      .bit_sel_i  (bus_addr_i[2:0]),
      .bit_i      (bus_wdata_i[io_pkg::DATA_W-1]),
      .flip_o     (flip),
      .led_o      (led_o),
      .coin_ctr_o (coin_ctr_o)
   );

   assign flip_o = flip;

   // cocktail flip swaps to the odd trackball pins
   assign {h_dir_pin, h_ck_pin, v_dir_pin, v_ck_pin} = flip ?
      {trakball_i[7], trakball_i[5], trakball_i[3], trakball_i[1]} :
      {trakball_i[6], trakball_i[4], trakball_i[2], trakball_i[0]};

   trakball_axis h_axis_inst (
      .s_6mhz  (s_6mhz),
      .reset   (reset),
      .ck_i    (h_ck_pin),
      .dir_i   (h_dir_pin),
      .clr_i   (steer_clr),
      .count_o (h_count),
      .dir_o   (h_dir)
   );

   trakball_axis v_axis_inst (
      .s_6mhz  (s_6mhz),
      .reset   (reset),
      .ck_i    (v_ck_pin),
      .dir_i   (v_dir_pin),
      .clr_i   (steer_clr),
      .count_o (v_count),
      .dir_o   (v_dir)
   );

   io_read_mux read_inst (
      .sel_i      (sel),
      .a0_i       (bus_addr_i[0]),
      .player_i   (player_i),
      .joystick_i (joystick_i),
      .sw1_i      (sw1_i),
      .sw2_i      (sw2_i),
      .h_count_i  (h_count),
      .v_count_i  (v_count),
      .h_dir_i    (h_dir),
      .v_dir_i    (v_dir),
      .rdata_o    (bus_rdata_o)
   );

endmodule

// ==== test/tb_model.svh ====
// reference model of the centipede io block, latch, trackball counters and read map
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// axis index 0 is horizontal, 1 is vertical
logic [io_pkg::DATA_W-1:0]   m_latch;
logic [1:0]                  m_ck1;
logic [1:0]                  m_ck2;
logic [1:0]                  m_ck3;
logic [1:0]                  m_dr1;
logic [1:0]                  m_dr2;
logic [1:0]                  m_dir;
logic [io_pkg::TB_CNT_W-1:0] m_count [2];

task automatic model_reset();
   m_latch = '0;
   m_ck1 = '0;
   m_ck2 = '0;
   m_ck3 = '0;
   m_dr1 = '0;
   m_dr2 = '0;
   m_dir = '0;
   m_count[0] = '0;
   m_count[1] = '0;
endtask

// one rising clock edge, called with the inputs the DUT samples at that edge
task automatic model_update();
   logic [1:0] ck_pin;
   logic [1:0] dr_pin;
   logic [1:0] rise;
   logic [3:0] region;
   logic       wr;
   int         base;
   base = m_latch[io_pkg::FLIP_BIT] ? 1 : 0;
   ck_pin = {trakball_i[base], trakball_i[4 + base]};
   dr_pin = {trakball_i[2 + base], trakball_i[6 + base]};
   region = bus_addr_i[13:10];
   wr = bus_wr_i && !bus_rw_n_i;
   // edge seen between the second stage and its previous value
   rise = m_ck2 & ~m_ck3;
   for (int a = 0; a < 2; a++)
   begin
      if (rise[a])
         m_dir[a] = m_dr2[a];
      if (wr && region == io_pkg::REGION_STEER)
         m_count[a] = '0;
      else if (rise[a])
         m_count[a] = m_dr2[a] ? m_count[a] + 4'd1 : m_count[a] - 4'd1;
   end
   m_ck3 = m_ck2;
   m_ck2 = m_ck1;
   m_ck1 = ck_pin;
   m_dr2 = m_dr1;
   m_dr1 = dr_pin;
   if (wr && region == io_pkg::REGION_OUT0)
      m_latch[bus_addr_i[2:0]] = bus_wdata_i[7];
endtask

// read data predicted from the address, the inputs and the model state
function automatic logic [7:0] expected_rdata();
   logic [3:0]          region;
   logic                a0;
   logic [io_pkg::PLAYER_W-1:0] p;
   region = bus_addr_i[13:10];
   a0 = bus_addr_i[0];
   p = player_i;
   if (!bus_rw_n_i)
      return 8'h00;
   if (region == io_pkg::REGION_INPUT && !bus_addr_i[1])
      return a0 ? {p[9], p[8], p[7], p[4], p[1], p[0], p[3], p[2]}
                : {m_dir[0], 1'b0, p[6], p[5], m_count[0]};
   if (region == io_pkg::REGION_INPUT)
      return a0 ? joystick_i : {m_dir[1], 3'b000, m_count[1]};
   if (region == io_pkg::REGION_SWITCH)
      return a0 ? sw2_i : sw1_i;
   return 8'h00;
endfunction

`endif

// ==== test/tb_centipede_io.sv ====
// testbench for the centipede io block, random bus and trackball traffic against a model
`timescale 1ns/1ps

module tb_centipede_io;

   localparam int CLK_PERIOD = 100;
   localparam int N_READ = 200;
   localparam int N_LATCH = 100;
   localparam int N_TRAK = 60;
   localparam int N_CLR = 150;
   localparam int N_MISC = 200;
   // longest trackball segment is 5 cycles, each flip setting costs a write and an idle cycle
   localparam int TOTAL_CYCLES = 4 + 1 + N_READ + 2 * N_LATCH + 2 * (2 + 5 * N_TRAK)
                                 + N_CLR + N_MISC;

   logic                        s_6mhz;
   logic                        reset;
   logic [io_pkg::ADDR_W-1:0]   bus_addr_i;
   logic [io_pkg::DATA_W-1:0]   bus_wdata_i;
   logic                        bus_rw_n_i;
   logic                        bus_wr_i;
   logic [io_pkg::DATA_W-1:0]   bus_rdata_o;
   logic [io_pkg::PLAYER_W-1:0] player_i;
   logic [7:0]                  joystick_i;
   logic [7:0]                  sw1_i;
   logic [7:0]                  sw2_i;
   logic [io_pkg::TB_W-1:0]     trakball_i;
   logic                        flip_o;
   logic [io_pkg::LED_W-1:0]    led_o;
   logic [io_pkg::COIN_W-1:0]   coin_ctr_o;
   logic [31:0]                 lfsr_state;
   int                          checks;
   int                          errors;

   `include "tb_model.svh"

   centipede_io centipede_io_inst (.*);

   always #(CLK_PERIOD / 2) s_6mhz = ~s_6mhz;

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic drive_bus(input logic rw_n, input logic wr, input logic [13:0] addr,
                            input logic [7:0] wdata);
      bus_rw_n_i <= rw_n;
      bus_wr_i <= wr;
      bus_addr_i <= addr;
      bus_wdata_i <= wdata;
   endtask

   // compare at the falling edge, then advance the model with the next rising edge
   task automatic next_cycle();
      @(negedge s_6mhz);
      check_value("bus_rdata_o", bus_rdata_o, expected_rdata());
      check_value("flip_o", 8'(flip_o), 8'(m_latch[io_pkg::FLIP_BIT]));
      check_value("led_o", 8'(led_o), 8'(m_latch[io_pkg::LED_LSB +: io_pkg::LED_W]));
      check_value("coin_ctr_o", 8'(coin_ctr_o), 8'(m_latch[io_pkg::COIN_W-1:0]));
      @(posedge s_6mhz);
      model_update();
   endtask

   task automatic read_counts();
      drive_bus(1'b1, 1'b0, {4'd3, 8'd0, rand_bits(1) == 1, 1'b0}, 8'(rand_bits(8)));
      next_cycle();
   endtask

   task automatic set_flip(input logic value);
      drive_bus(1'b0, 1'b1, {4'd7, 7'd0, 3'd7}, {value, 7'(rand_bits(7))});
      next_cycle();
      read_counts();
   endtask

   task automatic trackball_segments(input int n);
      int hold;
      for (int i = 0; i < n; i++)
      begin
         trakball_i <= 8'(rand_bits(8));
         hold = 2 + int'(rand_bits(2));
         repeat (hold) read_counts();
      end
   endtask

   initial
   begin
      #((TOTAL_CYCLES + 100) * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, errors so far %0d", TOTAL_CYCLES + 100,
               errors);
      $display("ERRORS FOUND");
      $finish;
   end

   initial
   begin
      logic [3:0] region;
      logic       rw_n;
      s_6mhz = 1'b0;
      lfsr_state = 32'hab0;
      checks = 0;
      errors = 0;
      reset <= 1'b1;
      drive_bus(1'b1, 1'b0, '0, '0);
      player_i <= '0;
      joystick_i <= '0;
      sw1_i <= '0;
      sw2_i <= '0;
      trakball_i <= '0;
      model_reset();
      repeat (3) @(posedge s_6mhz);
      reset <= 1'b0;

      // vertical word right after reset
      drive_bus(1'b1, 1'b0, {4'd3, 8'd0, 2'b10}, 8'h00);
      next_cycle();

      // switch, in0 and in1 words with random inputs
      for (int i = 0; i < N_READ; i++)
      begin
         player_i <= 10'(rand_bits(10));
         joystick_i <= 8'(rand_bits(8));
         sw1_i <= 8'(rand_bits(8));
         sw2_i <= 8'(rand_bits(8));
         region = rand_bits(1) == 1 ? 4'd3 : 4'd2;
         drive_bus(1'b1, 1'b0, {region, 10'(rand_bits(10))}, 8'h00);
         next_cycle();
      end

      // latch writes, each followed by an idle read so the new bit shows
      for (int i = 0; i < N_LATCH; i++)
      begin
         drive_bus(1'b0, 1'b1, {4'd7, 7'(rand_bits(7)), 3'(rand_bits(3))}, 8'(rand_bits(8)));
         next_cycle();
         read_counts();
      end

      set_flip(1'b0);
      trackball_segments(N_TRAK);
      set_flip(1'b1);
      trackball_segments(N_TRAK);

      // steering clear mixed in with pins changing every 2 cycles
      for (int i = 0; i < N_CLR; i++)
      begin
         if (i % 2 == 0)
            trakball_i <= 8'(rand_bits(8));
         if (rand_bits(2) == 0)
            drive_bus(1'b0, 1'b1, {4'd9, 10'(rand_bits(10))}, 8'(rand_bits(8)));
         else
            drive_bus(1'b1, 1'b0, {4'd3, 8'd0, rand_bits(1) == 1, 1'b0}, 8'h00);
         next_cycle();
      end

      // unmapped reads, writes elsewhere and strobes during reads
      for (int i = 0; i < N_MISC; i++)
      begin
         region = 4'(rand_bits(4));
         rw_n = rand_bits(1) == 1;
         if (!rw_n && (region == 4'd7 || region == 4'd9))
            region = region - 4'd1;
         drive_bus(rw_n, rand_bits(1) == 1, {region, 10'(rand_bits(10))}, 8'(rand_bits(8)));
         next_cycle();
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+test
source/io_pkg.sv
source/io_addr_decode.sv
source/trakball_axis.sv
source/coin_led_latch.sv
source/io_read_mux.sv
source/centipede_io.sv
test/tb_centipede_io.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the centipede io testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f files.f --top-module tb_centipede_io -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
   exit 1
fi
exit 0
